/* rtl/pt_walk_pkg.sv */
package pt_walk_pkg;

    // ==================================================================
    // Page table geometry
    // ==================================================================

    // Each table page holds 512 entries, so 9 index bits per level
    localparam int PT_IDX_WIDTH = 9;
    localparam int PT_MAX_DEPTH = 4;

    // One memory line carries 8 entries of 64 bits
    localparam int PT_WORDS_PER_LINE = 8;
    localparam int PT_WORD_IDX_WIDTH = $clog2(PT_WORDS_PER_LINE);

    // Cache geometry: index is the depth next to 2 low tag bits
    localparam int PT_CACHE_ENTRIES = 16;
    localparam int PT_CACHE_IDX_WIDTH = $clog2(PT_CACHE_ENTRIES);
    localparam int PT_TAG_WIDTH = PT_IDX_WIDTH * PT_MAX_DEPTH - PT_WORD_IDX_WIDTH;

    localparam int PA_PAGE_WIDTH = 28;
    localparam int LINE_ADDR_WIDTH = 34;

    typedef logic [PT_IDX_WIDTH-1:0] pt_idx_t;
    typedef logic [$clog2(PT_MAX_DEPTH)-1:0] pt_depth_t;

    // Element 3 is level 0, the top bits of the VA
    typedef pt_idx_t [PT_MAX_DEPTH-1:0] pt_idx_vec_t;

    typedef logic [PT_IDX_WIDTH*PT_MAX_DEPTH-1:0] va_page_t;
    typedef logic [PA_PAGE_WIDTH-1:0] pa_page_t;
    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
    typedef logic [63:0] pt_word_t;
    typedef pt_word_t [PT_WORDS_PER_LINE-1:0] pt_line_t;

    typedef struct packed {
        logic error;
        logic terminal;
    } pt_status_t;

    typedef struct packed {
        pa_page_t   page;
        pt_status_t status;
    } pt_entry_t;

    // Path of indices down to the wanted entry, plus the level
    typedef struct packed {
        pt_idx_vec_t idx_vec;
        pt_depth_t   depth;
    } pt_key_t;

    typedef struct packed {
        va_page_t va;
        pa_page_t pa;
        logic     big_page;
    } fill_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        CACHE_WAIT,
        READ_REQ,
        READ_WAIT,
        ENTRY,
        DONE,
        ERROR
    } walk_state_t;

    // Bit 0 terminal, bit 1 error, bits 39:12 the page
    function automatic pt_entry_t entry_from_word(pt_word_t w);
        pt_entry_t e;
        e.page = w[12 +: PA_PAGE_WIDTH];
        e.status.error = w[1];
        e.status.terminal = w[0];
        return e;
    endfunction

endpackage

/* rtl/pt_walk_cache.sv */
`timescale 1ns/100ps

module pt_walk_cache
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inval,
    input  pt_walk_pkg::pt_key_t   key,
    input  logic                   lookup_en,
    output logic                   cache_rdy,
    output logic                   hit,
    output logic                   miss,
    output pt_walk_pkg::pt_entry_t entry,
    input  logic                   line_valid,
    input  pt_walk_pkg::pt_line_t  line
);
    import pt_walk_pkg::*;

    typedef logic [PT_CACHE_IDX_WIDTH-1:0] cache_idx_t;
    typedef logic [PT_TAG_WIDTH-1:0] cache_tag_t;
    typedef logic [PT_WORD_IDX_WIDTH-1:0] word_idx_t;

    // Tag drops the word select bits of the index path
    function automatic cache_tag_t cache_tag(pt_key_t k);
        va_page_t path;
        path = k.idx_vec;
        return path[$bits(va_page_t)-1:PT_WORD_IDX_WIDTH];
    endfunction

    // Each depth owns its own quarter of the cache
    function automatic cache_idx_t cache_idx(pt_key_t k);
        cache_tag_t t;
        t = cache_tag(k);
        return {k.depth, t[1:0]};
    endfunction

    // ==================================================================
    // Storage
    // ==================================================================

    cache_tag_t tag_mem [PT_CACHE_ENTRIES];
    pt_entry_t  data_mem [PT_CACHE_ENTRIES*PT_WORDS_PER_LINE];
    logic [PT_CACHE_ENTRIES-1:0] valid;

    // Insert side
    logic       insert_busy;
    logic       ins_last;
    cache_idx_t ins_idx;
    cache_tag_t ins_tag;
    word_idx_t  ins_word;
    pt_line_t   ins_words;

    // Lookup side
    cache_idx_t lookup_idx;
    word_idx_t  lookup_word;
    logic       lookup_q;
    cache_tag_t tgt_tag_q;
    cache_tag_t rd_tag_q;
    logic       rd_valid_q;
    pt_entry_t  rd_entry_q;
    logic       match;

    // No lookup may overlap an insert
    assign cache_rdy = !insert_busy;

    assign lookup_idx = cache_idx(key);
    assign lookup_word = key.idx_vec[0][PT_WORD_IDX_WIDTH-1:0];

    // ==================================================================
    // Lookup pipeline
    // ==================================================================

    // Stage 1: read tag, valid and data word
    always_ff @(posedge clk)
    begin
        tgt_tag_q <= cache_tag(key);
        rd_tag_q <= tag_mem[lookup_idx];
        rd_valid_q <= valid[lookup_idx];
        rd_entry_q <= data_mem[{lookup_idx, lookup_word}];
    end

    // Error entries never hit, so they get read again every walk
    assign match = rd_valid_q && (rd_tag_q == tgt_tag_q) && !rd_entry_q.status.error;

    // Stage 2: registered hit or miss
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lookup_q <= 1'b0;
            hit <= 1'b0;
            miss <= 1'b0;
        end
        else
        begin
            lookup_q <= lookup_en;
            hit <= lookup_q && match;
            miss <= lookup_q && !match;
        end
    end

    always_ff @(posedge clk)
    begin
        entry <= rd_entry_q;
    end

    // ==================================================================
    // Insert, one word per cycle
    // ==================================================================

    assign ins_last = insert_busy && (&ins_word);

    always_ff @(posedge clk)
    begin
        // Inval also drops a half-written line
        if (reset || inval)
        begin
            insert_busy <= 1'b0;
            ins_word <= '0;
        end
        else if (line_valid)
        begin
            insert_busy <= 1'b1;
            ins_word <= '0;
        end
        else if (insert_busy)
        begin
            ins_word <= ins_word + word_idx_t'(1);
            if (ins_last)
            begin
                insert_busy <= 1'b0;
            end
        end
    end

    // Capture the line, then shift so word 0 is always the next to write
    always_ff @(posedge clk)
    begin
        if (line_valid)
        begin
            ins_idx <= cache_idx(key);
            ins_tag <= cache_tag(key);
            ins_words <= line;
        end
        else if (insert_busy)
        begin
            for (int w = 0; w < PT_WORDS_PER_LINE - 1; w++)
            begin
                ins_words[w] <= ins_words[w + 1];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (insert_busy)
        begin
            data_mem[{ins_idx, ins_word}] <= entry_from_word(ins_words[0]);
        end
        // Tag goes in with the last word
        if (ins_last)
        begin
            tag_mem[ins_idx] <= ins_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || inval)
        begin
            valid <= '0;
        end
        else if (ins_last)
        begin
            valid[ins_idx] <= 1'b1;
        end
    end

endmodule

/* rtl/pt_line_reader.sv */
`timescale 1ns/100ps

module pt_line_reader
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      read_data_en,
    input  pt_walk_pkg::pt_line_t                     read_data,
    input  logic [pt_walk_pkg::PT_WORD_IDX_WIDTH-1:0] word_idx,
    output logic                                      line_valid,
    output pt_walk_pkg::pt_line_t                     line,
    output logic                                      entry_valid,
    output pt_walk_pkg::pt_entry_t                    entry
);
    import pt_walk_pkg::*;

    // Word picked out of the registered line
    pt_word_t sel_word;

    // ==================================================================
    // Strobes
    // ==================================================================

    // Line one cycle after the response, entry one cycle later
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line_valid <= 1'b0;
            entry_valid <= 1'b0;
        end
        else
        begin
            line_valid <= read_data_en;
            entry_valid <= line_valid;
        end
    end

    // ==================================================================
    // Data path
    // ==================================================================

    // Response register, cuts the path from the memory side
    always_ff @(posedge clk)
    begin
        if (read_data_en)
        begin
            line <= read_data;
        end
    end

    assign sel_word = line[word_idx];

    // Decode only the word the walk asked for
    always_ff @(posedge clk)
    begin
        if (line_valid)
        begin
            entry <= entry_from_word(sel_word);
        end
    end

endmodule

/* rtl/pt_walk_fsm.sv */
`timescale 1ns/100ps

module pt_walk_fsm
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      enable,
    input  pt_walk_pkg::pa_page_t                     root_page,
    input  logic                                      req_en,
    input  pt_walk_pkg::va_page_t                     req_va,
    output logic                                      req_rdy,
    input  logic                                      cache_rdy,
    output logic                                      lookup_en,
    output pt_walk_pkg::pt_key_t                      key,
    input  logic                                      hit,
    input  logic                                      miss,
    input  pt_walk_pkg::pt_entry_t                    cache_entry,
    input  logic                                      read_rdy,
    output logic                                      read_en,
    output pt_walk_pkg::line_addr_t                   read_addr,
    input  logic                                      entry_valid,
    input  pt_walk_pkg::pt_entry_t                    reader_entry,
    output logic [pt_walk_pkg::PT_WORD_IDX_WIDTH-1:0] word_idx,
    input  logic                                      fill_rdy,
    output logic                                      fill_en,
    output pt_walk_pkg::fill_t                        fill,
    output logic                                      not_present,
    output logic                                      busy
);
    import pt_walk_pkg::*;

    walk_state_t state;
    logic        enabled_q;

    // Walk context
    va_page_t    va;
    pt_idx_vec_t va_vec;
    pt_idx_vec_t idx_vec;
    pt_depth_t   depth;
    pa_page_t    cur_page;
    pt_entry_t   cur_entry;

    // Decisions taken in ENTRY
    logic start;
    logic last_level;
    logic descend;
    logic finish;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            enabled_q <= 1'b0;
        end
        else
        begin
            enabled_q <= enable;
        end
    end

    assign va_vec = va;
    assign last_level = (depth == pt_depth_t'(PT_MAX_DEPTH - 1));

    // One walk at a time
    assign req_rdy = (state == IDLE) && enabled_q;
    assign start = req_en && req_rdy;

    // Pointer to the next table, only above the last level
    assign descend = (state == ENTRY) && !cur_entry.status.error &&
                     !cur_entry.status.terminal && !last_level;

    // Terminal only counts at level 2 (big page) or 3 (4 KB)
    assign finish = (state == ENTRY) && !cur_entry.status.error &&
                    cur_entry.status.terminal && depth[1];

    // ==================================================================
    // State register
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:       if (start) state <= LOOKUP;
                LOOKUP:     if (cache_rdy) state <= CACHE_WAIT;
                CACHE_WAIT:
                begin
                    if (hit)
                        state <= ENTRY;
                    else if (miss)
                        state <= READ_REQ;
                end
                READ_REQ:   if (read_rdy) state <= READ_WAIT;
                READ_WAIT:  if (entry_valid) state <= ENTRY;
                ENTRY:
                begin
                    // Anything that neither descends nor finishes is not present
                    if (descend)
                        state <= LOOKUP;
                    else if (finish)
                        state <= DONE;
                    else
                        state <= ERROR;
                end
                DONE:       if (fill_rdy) state <= IDLE;
                // Single-cycle not_present, then ready again
                ERROR:      state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    // ==================================================================
    // Walk context
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            va <= req_va;
            // Key path holds only the level 0 index at first
            idx_vec <= pt_idx_vec_t'(req_va >> (PT_IDX_WIDTH * (PT_MAX_DEPTH - 1)));
            depth <= '0;
            cur_page <= root_page;
        end
        else if (descend)
        begin
            // Append the index of the next level to the path
            idx_vec <= {idx_vec[PT_MAX_DEPTH-2:0], va_vec[pt_depth_t'(2) - depth]};
            depth <= depth + pt_depth_t'(1);
            cur_page <= cur_entry.page;
        end
        else if (finish)
        begin
            cur_page <= cur_entry.page;
        end

        // Entry comes from the cache on a hit or from the reader
        if ((state == CACHE_WAIT) && hit)
            cur_entry <= cache_entry;
        else if ((state == READ_WAIT) && entry_valid)
            cur_entry <= reader_entry;
    end

    // ==================================================================
    // Outputs
    // ==================================================================

    assign lookup_en = (state == LOOKUP) && cache_rdy;
    assign key = '{idx_vec: idx_vec, depth: depth};

    // Current table page, then the line within it
    assign read_en = (state == READ_REQ) && read_rdy;
    assign read_addr = {cur_page, idx_vec[0][PT_IDX_WIDTH-1:PT_WORD_IDX_WIDTH]};
    assign word_idx = idx_vec[0][PT_WORD_IDX_WIDTH-1:0];

    assign fill_en = (state == DONE) && fill_rdy;
    assign fill = '{va: va, pa: cur_page, big_page: (depth == pt_depth_t'(2))};

    assign not_present = (state == ERROR);
    assign busy = (state != IDLE);

endmodule

/* rtl/pt_walk_top.sv */
`timescale 1ns/100ps

module pt_walk_top
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    input  pt_walk_pkg::pa_page_t   root_page,
    input  logic                    inval,
    input  logic                    req_en,
    input  pt_walk_pkg::va_page_t   req_va,
    output logic                    req_rdy,
    input  logic                    read_rdy,
    output logic                    read_en,
    output pt_walk_pkg::line_addr_t read_addr,
    input  logic                    read_data_en,
    input  pt_walk_pkg::pt_line_t   read_data,
    input  logic                    fill_rdy,
    output logic                    fill_en,
    output pt_walk_pkg::fill_t      fill,
    output logic                    not_present,
    output logic                    busy
);
    import pt_walk_pkg::*;

    // Cache side
    pt_key_t   key;
    logic      lookup_en;
    logic      cache_rdy;
    logic      hit;
    logic      miss;
    pt_entry_t cache_entry;

    // Reader side
    logic                         line_valid;
    pt_line_t                     line;
    logic                         entry_valid;
    pt_entry_t                    reader_entry;
    logic [PT_WORD_IDX_WIDTH-1:0] word_idx;

    // Cached table lines, filled from the reader
    pt_walk_cache i_cache (
        .clk        (clk),
        .reset      (reset),
        .inval      (inval),
        .key        (key),
        .lookup_en  (lookup_en),
        .cache_rdy  (cache_rdy),
        .hit        (hit),
        .miss       (miss),
        .entry      (cache_entry),
        .line_valid (line_valid),
        .line       (line)
    );

    // Memory responses
    pt_line_reader i_reader (
        .clk          (clk),
        .reset        (reset),
        .read_data_en (read_data_en),
        .read_data    (read_data),
        .word_idx     (word_idx),
        .line_valid   (line_valid),
        .line         (line),
        .entry_valid  (entry_valid),
        .entry        (reader_entry)
    );

    pt_walk_fsm i_fsm (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .root_page    (root_page),
        .req_en       (req_en),
        .req_va       (req_va),
        .req_rdy      (req_rdy),
        .cache_rdy    (cache_rdy),
        .lookup_en    (lookup_en),
        .key          (key),
        .hit          (hit),
        .miss         (miss),
        .cache_entry  (cache_entry),
        .read_rdy     (read_rdy),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .entry_valid  (entry_valid),
        .reader_entry (reader_entry),
        .word_idx     (word_idx),
        .fill_rdy     (fill_rdy),
        .fill_en      (fill_en),
        .fill         (fill),
        .not_present  (not_present),
        .busy         (busy)
    );

endmodule

/* tb/pt_mem_model.sv */
`timescale 1ns/100ps

module pt_mem_model
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    read_en,
    input  pt_walk_pkg::line_addr_t read_addr,
    input  int                      resp_delay,
    output logic                    read_data_en,
    output pt_walk_pkg::pt_line_t   read_data
);
    import pt_walk_pkg::*;

    // Sparse store, only lines of the test page table exist
    pt_line_t lines [line_addr_t];

    // Place one entry into the line that holds it
    task automatic write_entry(input pa_page_t table_page, input pt_idx_t idx, input pt_word_t w);
        line_addr_t addr;
        pt_line_t   ln;
        addr = {table_page, idx[PT_IDX_WIDTH-1:PT_WORD_IDX_WIDTH]};
        ln = '0;
        if (lines.exists(addr))
            ln = lines[addr];
        ln[idx[PT_WORD_IDX_WIDTH-1:0]] = w;
        lines[addr] = ln;
    endtask

    // Unwritten lines read back as zero
    function automatic pt_line_t fetch_line(line_addr_t addr);
        if (lines.exists(addr))
            return lines[addr];
        return '0;
    endfunction

    // ==================================================================
    // Read responses, one per request after resp_delay cycles
    // ==================================================================

    initial
    begin
        line_addr_t addr;
        int         delay;
        read_data_en = 1'b0;
        read_data = '0;
        forever
        begin
            @(posedge clk);
            if (!reset && read_en)
            begin
                addr = read_addr;
                delay = resp_delay;
                repeat (delay) @(posedge clk);
                #10;
                read_data_en = 1'b1;
                read_data = fetch_line(addr);
                @(posedge clk);
                #10;
                read_data_en = 1'b0;
            end
        end
    end

endmodule

/* tb/pt_walk_tb.sv */
`timescale 1ns/100ps

module pt_walk_tb;
    import pt_walk_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS = 10;
    // Four levels with stalls and slow responses fit well inside 200 cycles
    localparam int WALK_NS = 20000;

    localparam pa_page_t ROOT = 28'h0000100;
    localparam pa_page_t P1 = 28'h0000200;
    localparam pa_page_t P2 = 28'h0000300;
    localparam pa_page_t P3 = 28'h0000400;
    localparam pa_page_t P4 = 28'h0000500;
    localparam pa_page_t LEAF_A = 28'h00abcde;
    localparam pa_page_t LEAF_B = 28'h0012345;
    localparam pa_page_t LEAF_C = 28'h00055aa;
    localparam pa_page_t BIG_D = 28'h0777000;
    localparam pa_page_t BIG_E = 28'h0888000;
    localparam pa_page_t TERM_L1 = 28'h0999000;

    // One walk and what it must produce
    typedef struct packed {
        va_page_t va;
        logic     inval_before;
        logic     exp_not_present;
        pa_page_t exp_pa;
        logic     exp_big;
        int       exp_reads;
    } row_t;

    logic       clk;
    logic       reset;
    logic       enable;
    pa_page_t   root_page;
    logic       inval;
    logic       req_en;
    va_page_t   req_va;
    logic       req_rdy;
    logic       read_rdy;
    logic       read_en;
    line_addr_t read_addr;
    logic       read_data_en;
    pt_line_t   read_data;
    logic       fill_rdy;
    logic       fill_en;
    fill_t      fill;
    logic       not_present;
    logic       busy;

    // Memory response delay in cycles
    int   resp_delay;
    int   read_count;
    row_t rows [NUM_ROWS];

    pt_walk_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .root_page    (root_page),
        .inval        (inval),
        .req_en       (req_en),
        .req_va       (req_va),
        .req_rdy      (req_rdy),
        .read_rdy     (read_rdy),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .read_data_en (read_data_en),
        .read_data    (read_data),
        .fill_rdy     (fill_rdy),
        .fill_en      (fill_en),
        .fill         (fill),
        .not_present  (not_present),
        .busy         (busy)
    );

    pt_mem_model i_mem (
        .clk          (clk),
        .reset        (reset),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .resp_delay   (resp_delay),
        .read_data_en (read_data_en),
        .read_data    (read_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Memory reads seen on the request side
    initial read_count = 0;
    always @(posedge clk)
    begin
        if (!reset && read_en)
            read_count <= read_count + 1;
    end

    initial
    begin
        #(RESET_CYCLES * CLK_PERIOD + NUM_ROWS * WALK_NS);
        $display("watchdog timeout: walk did not finish");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    // ==================================================================
    // Helpers
    // ==================================================================

    // Random back-pressure, about one stalled cycle in four, and 1 to 6 cycle responses
    task automatic drive_stalls();
        forever
        begin
            @(posedge clk);
            #10;
            read_rdy = ($urandom % 4) != 0;
            fill_rdy = ($urandom % 4) != 0;
            resp_delay = $urandom % 6 + 1;
        end
    endtask

    function automatic va_page_t va_from_idx(pt_idx_t l0, pt_idx_t l1, pt_idx_t l2, pt_idx_t l3);
        return {l0, l1, l2, l3};
    endfunction

    // Page in bits 39:12, error bit 1, terminal bit 0
    function automatic pt_word_t pte_word(pa_page_t page, logic terminal, logic error);
        pt_word_t w;
        w = '0;
        w[39:12] = page;
        w[1] = error;
        w[0] = terminal;
        return w;
    endfunction

    function automatic row_t table_row(va_page_t va, logic inval_before, logic exp_np,
                                       pa_page_t exp_pa, logic exp_big, int exp_reads);
        row_t r;
        r.va = va;
        r.inval_before = inval_before;
        r.exp_not_present = exp_np;
        r.exp_pa = exp_pa;
        r.exp_big = exp_big;
        r.exp_reads = exp_reads;
        return r;
    endfunction

    task automatic fill_compare(input string name, input fill_t actual, input fill_t expected);
        if (actual !== expected)
        begin
            $display("FAIL time=%0t %s expected va=%h pa=%h big=%b actual va=%h pa=%h big=%b",
                     $time, name, expected.va, expected.pa, expected.big_page,
                     actual.va, actual.pa, actual.big_page);
            $display("Testbench failed");
            $fatal(1, "fill mismatch");
        end
    endtask

    task automatic flag_compare(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic count_compare(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("FAIL time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "count mismatch");
        end
    endtask

    // Starts and ends 10 ns after a rising edge, with the walker idle
    task automatic pulse_inval();
        inval = 1'b1;
        @(posedge clk);
        #10;
        inval = 1'b0;
    endtask

    task automatic run_walk(input row_t r);
        int    reads_before;
        logic  got_np;
        fill_t got_fill;
        fill_t exp_fill;
        if (r.inval_before)
            pulse_inval();
        reads_before = read_count;
        req_va = r.va;
        req_en = 1'b1;
        do
            @(posedge clk);
        while (!req_rdy);
        #10;
        req_en = 1'b0;
        req_va = '0;
        flag_compare("busy", busy, 1'b1);
        // Walk ends with a fill handshake or a not_present pulse
        do
            @(posedge clk);
        while (!fill_en && !not_present);
        got_np = not_present;
        got_fill = fill;
        exp_fill = '{va: r.va, pa: r.exp_pa, big_page: r.exp_big};
        flag_compare("not_present", got_np, r.exp_not_present);
        if (!r.exp_not_present)
            fill_compare("fill", got_fill, exp_fill);
        count_compare("read_count", read_count - reads_before, r.exp_reads);
        #10;
        flag_compare("busy", busy, 1'b0);
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial
    begin
        void'($urandom(32'hc034));
        reset = 1'b1;
        enable = 1'b1;
        root_page = ROOT;
        inval = 1'b0;
        req_en = 1'b0;
        req_va = '0;
        read_rdy = 1'b0;
        fill_rdy = 1'b0;
        resp_delay = 1;

        fork
            drive_stalls();
        join_none

        // Page table, pointers carry neither terminal nor error
        i_mem.write_entry(ROOT, 9'h001, pte_word(P1, 1'b0, 1'b0));
        i_mem.write_entry(ROOT, 9'h003, pte_word(28'h0000bad, 1'b0, 1'b1));
        i_mem.write_entry(P1, 9'h002, pte_word(P2, 1'b0, 1'b0));
        i_mem.write_entry(P1, 9'h004, pte_word(TERM_L1, 1'b1, 1'b0));
        i_mem.write_entry(P1, 9'h048, pte_word(P4, 1'b0, 1'b0));
        i_mem.write_entry(P2, 9'h003, pte_word(P3, 1'b0, 1'b0));
        i_mem.write_entry(P2, 9'h005, pte_word(BIG_D, 1'b1, 1'b0));
        i_mem.write_entry(P3, 9'h010, pte_word(LEAF_A, 1'b1, 1'b0));
        i_mem.write_entry(P3, 9'h013, pte_word(LEAF_B, 1'b1, 1'b0));
        i_mem.write_entry(P3, 9'h020, pte_word(LEAF_C, 1'b1, 1'b0));
        i_mem.write_entry(P4, 9'h00f, pte_word(BIG_E, 1'b1, 1'b0));

        // Cold 4 KB walk, same leaf line, then another leaf line
        rows[0] = table_row(va_from_idx(9'h001, 9'h002, 9'h003, 9'h010), 0, 0, LEAF_A, 0, 4);
        rows[1] = table_row(va_from_idx(9'h001, 9'h002, 9'h003, 9'h013), 0, 0, LEAF_B, 0, 0);
        rows[2] = table_row(va_from_idx(9'h001, 9'h002, 9'h003, 9'h020), 0, 0, LEAF_C, 0, 1);
        // Big pages, one partly cold and one fully cached
        rows[3] = table_row(va_from_idx(9'h001, 9'h048, 9'h00f, 9'h1ab), 0, 0, BIG_E, 1, 2);
        rows[4] = table_row(va_from_idx(9'h001, 9'h002, 9'h005, 9'h1ff), 0, 0, BIG_D, 1, 0);
        // Error entry twice, then terminal at level 1
        rows[5] = table_row(va_from_idx(9'h003, 9'h000, 9'h000, 9'h000), 0, 1, '0, 0, 1);
        rows[6] = table_row(va_from_idx(9'h003, 9'h000, 9'h000, 9'h000), 0, 1, '0, 0, 1);
        rows[7] = table_row(va_from_idx(9'h001, 9'h004, 9'h011, 9'h022), 0, 1, '0, 0, 0);
        // Invalidate, then cold again
        rows[8] = table_row(va_from_idx(9'h001, 9'h002, 9'h003, 9'h010), 1, 0, LEAF_A, 0, 4);
        rows[9] = table_row(va_from_idx(9'h001, 9'h002, 9'h003, 9'h020), 0, 0, LEAF_C, 0, 1);

        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reset = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++)
            run_walk(rows[i]);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* Bender.yml */
package:
  name: pt_walk

sources:
  # Package first, then the RTL from the leaves up
  - rtl/pt_walk_pkg.sv
  - rtl/pt_walk_cache.sv
  - rtl/pt_line_reader.sv
  - rtl/pt_walk_fsm.sv
  - rtl/pt_walk_top.sv

  - target: test
    files:
      - tb/pt_mem_model.sv
      - tb/pt_walk_tb.sv

/* tb.f */
rtl/pt_walk_pkg.sv
rtl/pt_walk_cache.sv
rtl/pt_line_reader.sv
rtl/pt_walk_fsm.sv
rtl/pt_walk_top.sv
tb/pt_mem_model.sv
tb/pt_walk_tb.sv
